//--- build.f
dcache_cfg_pkg.sv
dcache_ctrl_pkg.sv
dcache_array_if.sv
dcache_tag.sv
dcache_data.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

  localparam int RESP_TIMEOUT = 200;  // cycles per request
  localparam int EV_RD_BURST  = 1;
  localparam int EV_WR_BURST  = 2;
  localparam int EV_RD_SINGLE = 3;
  localparam int EV_WR_SINGLE = 4;

  logic        clk;
  logic        rst;
  logic        req_valid_i;
  logic [31:0] req_addr_i;
  logic [7:0]  req_mask_i;
  logic        req_write_i;
  logic [63:0] req_wdata_i;
  logic        resp_ready_o;
  logic [63:0] resp_rdata_o;
  logic [31:0] mem_raddr_o;
  logic [7:0]  mem_rlen_o;
  logic        mem_rvalid_o;
  logic        mem_rready_i;
  logic [63:0] mem_rdata_i;
  logic [31:0] mem_waddr_o;
  logic [7:0]  mem_wlen_o;
  logic [7:0]  mem_wmask_o;
  logic [63:0] mem_wdata_o;
  logic        mem_wvalid_o;
  logic        mem_wready_i;

  logic [31:0] lfsr;
  logic [7:0]  model_mem [logic [31:0]];  // reference model as flat byte memory
  logic [63:0] resp_mem [logic [31:0]];   // backing store behind the responder
  logic        dir_valid [64];            // expected cache contents
  logic        dir_dirty [64];
  logic [19:0] dir_tag [64];
  int          traffic [$];               // completed transfers of the current request
  int          rd_beat;
  int          wr_beat;
  int          rd_hold;
  int          wr_hold;
  int          n_hits;
  int          n_evict;
  logic [31:0] cur_addr;
  logic [7:0]  cur_mask;
  logic [63:0] cur_wdata;
  logic        cur_write;
  logic        cur_uc;

  dcache_top #(.NUM_LINES(64)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;  // galois step
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] fill_word(input logic [31:0] a);
    return {a ^ 32'h5ca1_ab1e, ~a};
  endfunction

  function automatic logic [63:0] model_read(input logic [31:0] a);
    logic [63:0] w;
    w = fill_word(a);
    for (int b = 0; b < 8; b++) begin
      if (model_mem.exists(a + b)) begin
        w[8*b +: 8] = model_mem[a + b];
      end
    end
    return w;
  endfunction

  function automatic logic [63:0] resp_word(input logic [31:0] a);
    return resp_mem.exists(a) ? resp_mem[a] : fill_word(a);
  endfunction

  function automatic logic [19:0] tag_of(input logic [1:0] sel);
    case (sel)
      2'd0:    return 20'h00012;
      2'd1:    return 20'h00a40;
      2'd2:    return 20'h1f003;
      default: return 20'h7c0d9;
    endcase
  endfunction

  task automatic report_failure();
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic serve_read_beat();
    if (cur_uc) begin
      check_value(mem_rlen_o, 0, "uncached read length");
      check_value(mem_raddr_o, cur_addr, "uncached read address");
    end else begin
      check_value(mem_rlen_o, 7, "refill burst length");
      check_value(mem_raddr_o, {cur_addr[31:6], 6'd0}, "refill burst address");
    end
    mem_rready_i = 1'b1;
    mem_rdata_i  = resp_word(mem_raddr_o + 8 * rd_beat);
    rd_beat++;
    if (rd_beat == mem_rlen_o + 1) begin
      traffic.push_back(mem_rlen_o == 0 ? EV_RD_SINGLE : EV_RD_BURST);
      rd_beat = 0;
    end
    rd_hold = rand_bits(2);  // stall before next beat
  endtask

  task automatic serve_write_beat();
    logic [31:0] a;
    logic [63:0] w;
    a = mem_waddr_o + 8 * wr_beat;
    if (cur_write) begin
      check_value(mem_wlen_o, 0, "single write length");
      check_value(mem_waddr_o, cur_addr, "single write address");
      check_value(mem_wmask_o, cur_mask, "single write mask");
      check_value(mem_wdata_o, cur_wdata, "single write data");
    end else begin
      check_value(mem_wlen_o, 7, "write-back burst length");
      check_value(mem_waddr_o, {dir_tag[cur_addr[11:6]], cur_addr[11:6], 6'd0},
                  "write-back victim address");
      check_value(mem_wmask_o, 8'hff, "write-back mask");
      check_value(mem_wdata_o, model_read(a), "write-back data");
    end
    mem_wready_i = 1'b1;
    w = resp_word(a);
    for (int b = 0; b < 8; b++) begin
      if (mem_wmask_o[b]) begin
        w[8*b +: 8] = mem_wdata_o[8*b +: 8];
      end
    end
    resp_mem[a] = w;
    wr_beat++;
    if (wr_beat == mem_wlen_o + 1) begin
      traffic.push_back(mem_wlen_o == 0 ? EV_WR_SINGLE : EV_WR_BURST);
      wr_beat = 0;
    end
    wr_hold = rand_bits(2);
  endtask

  // memory responder acting 1 ns after each rising edge
  initial begin
    rd_beat = 0;
    wr_beat = 0;
    rd_hold = 0;
    wr_hold = 0;
    forever begin
      @(posedge clk);
      #1;
      mem_rready_i = 1'b0;
      mem_wready_i = 1'b0;
      if (mem_rvalid_o === 1'b1) begin
        if (rd_hold > 0) begin
          rd_hold--;
        end else begin
          serve_read_beat();
        end
      end
      if (mem_wvalid_o === 1'b1) begin
        if (wr_hold > 0) begin
          wr_hold--;
        end else begin
          serve_write_beat();
        end
      end
    end
  end

  task automatic wait_response(input int n, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (resp_ready_o !== 1'b1 && cycles < RESP_TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (resp_ready_o !== 1'b1) begin
      $display("request %0d to address %h got no response within %0d cycles",
               n, req_addr_i, RESP_TIMEOUT);
      report_failure();
    end
  endtask

  // called at a falling edge so random draws never overlap the responder
  task automatic run_request(input int n);
    logic [31:0] addr;
    logic [7:0]  mask;
    logic [63:0] data;
    logic [1:0]  tsel;
    logic [2:0]  isel;
    logic [2:0]  wsel;
    logic        wr;
    logic        uc;
    logic        hit;
    logic [5:0]  idx;
    int          exp_q [$];
    int          cycles;
    if (rand_bits(3) == 0) begin
      wsel = rand_bits(2);
      addr = {dcache_cfg_pkg::MMIO_BASE, 28'h000_0100} + 32'(wsel) * 8;
    end else begin
      tsel = rand_bits(2);
      isel = rand_bits(3);
      wsel = rand_bits(3);
      addr = {tag_of(tsel), 3'b000, isel, wsel, 3'b000};  // 4 tags on 8 lines
    end
    wr   = rand_bits(1);
    mask = rand_bits(8);
    data = rand_bits(64);
    if (mask == 0) begin
      mask = 8'h80;
    end
    uc  = addr[31:28] == dcache_cfg_pkg::MMIO_BASE;
    idx = addr[11:6];
    hit = !uc && dir_valid[idx] && dir_tag[idx] == addr[31:12];
    if (uc || (wr && !hit)) begin
      exp_q.push_back(wr ? EV_WR_SINGLE : EV_RD_SINGLE);
    end else if (!hit) begin
      if (dir_valid[idx] && dir_dirty[idx]) begin
        exp_q.push_back(EV_WR_BURST);  // dirty victim goes first
        n_evict++;
      end
      exp_q.push_back(EV_RD_BURST);
    end
    @(posedge clk);
    #1;
    check_value(resp_ready_o, 0, "response pulse longer than one cycle");
    cur_addr    = addr;
    cur_mask    = mask;
    cur_wdata   = data;
    cur_write   = wr;
    cur_uc      = uc;
    traffic.delete();
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_mask_i  = mask;
    req_write_i = wr;
    req_wdata_i = data;
    wait_response(n, cycles);
    check_value({mem_rvalid_o, mem_wvalid_o}, 2'b00, "memory transfer open at response");
    check_value(rd_beat, 0, "read beats left over at response");
    check_value(wr_beat, 0, "write beats left over at response");
    if (!wr) begin
      check_value(resp_rdata_o, model_read(addr), "read data");
    end
    if (hit) begin
      check_value(cycles, 2, "hit latency");
      n_hits++;
    end
    check_value(traffic.size(), exp_q.size(), "number of memory transfers");
    for (int i = 0; i < exp_q.size() && i < traffic.size(); i++) begin
      check_value(traffic[i], exp_q[i], "memory transfer kind and order");
    end
    if (wr) begin
      for (int b = 0; b < 8; b++) begin
        if (mask[b]) begin
          model_mem[addr + b] = data[8*b +: 8];
        end
      end
      if (hit) begin
        dir_dirty[idx] = 1'b1;
      end
    end else if (!uc && !hit) begin
      dir_valid[idx] = 1'b1;  // refilled and clean
      dir_tag[idx]   = addr[31:12];
      dir_dirty[idx] = 1'b0;
    end
  endtask

  initial begin
    lfsr         = 32'd11;
    n_hits       = 0;
    n_evict      = 0;
    rst          = 1'b1;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_mask_i   = '0;
    req_write_i  = 1'b0;
    req_wdata_i  = '0;
    mem_rready_i = 1'b0;
    mem_rdata_i  = '0;
    mem_wready_i = 1'b0;
    for (int i = 0; i < 64; i++) begin
      dir_valid[i] = 1'b0;
      dir_dirty[i] = 1'b0;
      dir_tag[i]   = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value(resp_ready_o, 0, "resp_ready_o after reset");
    check_value(mem_rvalid_o, 0, "mem_rvalid_o after reset");
    check_value(mem_wvalid_o, 0, "mem_wvalid_o after reset");
    for (int n = 0; n < 400; n++) begin
      run_request(n);
    end
    @(posedge clk);
    #1;
    check_value(resp_ready_o, 0, "response pulse longer than one cycle");
    req_valid_i = 1'b0;
    $display("400 requests, %0d hits, %0d dirty evictions", n_hits, n_evict);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
  parameter int NUM_LINES = 64  // power of two
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              req_valid_i,
  input  logic [dcache_cfg_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [dcache_cfg_pkg::XLEN/8-1:0] req_mask_i,
  input  logic                              req_write_i,
  input  logic [dcache_cfg_pkg::XLEN-1:0]   req_wdata_i,
  output logic                              resp_ready_o,
  output logic [dcache_cfg_pkg::XLEN-1:0]   resp_rdata_o,
  output logic [dcache_cfg_pkg::ADDR_W-1:0] mem_raddr_o,
  output logic [7:0]                        mem_rlen_o,
  output logic                              mem_rvalid_o,
  input  logic                              mem_rready_i,
  input  logic [dcache_cfg_pkg::XLEN-1:0]   mem_rdata_i,
  output logic [dcache_cfg_pkg::ADDR_W-1:0] mem_waddr_o,
  output logic [7:0]                        mem_wlen_o,
  output logic [dcache_cfg_pkg::XLEN/8-1:0] mem_wmask_o,
  output logic [dcache_cfg_pkg::XLEN-1:0]   mem_wdata_o,
  output logic                              mem_wvalid_o,
  input  logic                              mem_wready_i
);

  localparam int IDX_W = dcache_cfg_pkg::index_w_of(NUM_LINES);
  localparam int TAG_W = dcache_cfg_pkg::tag_w_of(NUM_LINES);

  logic [IDX_W-1:0] lookup_index;
  logic [TAG_W-1:0] lookup_tag;
  logic             tag_wen;
  logic             dirty_wen;
  logic             dirty_val;
  logic             hit;
  logic             dirty;
  logic [TAG_W-1:0] victim_tag;

  dcache_array_if #(.NUM_LINES(NUM_LINES)) u_arr_if ();

  dcache_ctrl #(.NUM_LINES(NUM_LINES)) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_mask_i     (req_mask_i),
    .req_write_i    (req_write_i),
    .req_wdata_i    (req_wdata_i),
    .resp_ready_o   (resp_ready_o),
    .resp_rdata_o   (resp_rdata_o),
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .tag_wen_o      (tag_wen),
    .dirty_wen_o    (dirty_wen),
    .dirty_val_o    (dirty_val),
    .hit_i          (hit),
    .dirty_i        (dirty),
    .victim_tag_i   (victim_tag),
    .arr            (u_arr_if.ctrl_mp),
    .mem_raddr_o    (mem_raddr_o),
    .mem_rlen_o     (mem_rlen_o),
    .mem_rvalid_o   (mem_rvalid_o),
    .mem_rready_i   (mem_rready_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_waddr_o    (mem_waddr_o),
    .mem_wlen_o     (mem_wlen_o),
    .mem_wmask_o    (mem_wmask_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_wvalid_o   (mem_wvalid_o),
    .mem_wready_i   (mem_wready_i)
  );

  dcache_tag #(.NUM_LINES(NUM_LINES)) u_tag (
    .clk          (clk),
    .rst          (rst),
    .index_i      (lookup_index),
    .tag_i        (lookup_tag),
    .tag_wen_i    (tag_wen),
    .dirty_wen_i  (dirty_wen),
    .dirty_val_i  (dirty_val),
    .hit_o        (hit),
    .dirty_o      (dirty),
    .victim_tag_o (victim_tag)
  );

  dcache_data #(.NUM_LINES(NUM_LINES)) u_data (
    .clk (clk),
    .rst (rst),
    .arr (u_arr_if.array_mp)
  );

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter int NUM_LINES = 64,
  localparam int IDX_W = dcache_cfg_pkg::index_w_of(NUM_LINES),
  localparam int TAG_W = dcache_cfg_pkg::tag_w_of(NUM_LINES)
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req_valid_i,
  input  logic [dcache_cfg_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [dcache_cfg_pkg::XLEN/8-1:0]   req_mask_i,
  input  logic                                req_write_i,
  input  logic [dcache_cfg_pkg::XLEN-1:0]     req_wdata_i,
  output logic                                resp_ready_o,
  output logic [dcache_cfg_pkg::XLEN-1:0]     resp_rdata_o,
  output logic [IDX_W-1:0]                    lookup_index_o,
  output logic [TAG_W-1:0]                    lookup_tag_o,
  output logic                                tag_wen_o,
  output logic                                dirty_wen_o,
  output logic                                dirty_val_o,
  input  logic                                hit_i,
  input  logic                                dirty_i,
  input  logic [TAG_W-1:0]                    victim_tag_i,
  dcache_array_if.ctrl_mp                     arr,
  output logic [dcache_cfg_pkg::ADDR_W-1:0]   mem_raddr_o,
  output logic [7:0]                          mem_rlen_o,
  output logic                                mem_rvalid_o,
  input  logic                                mem_rready_i,
  input  logic [dcache_cfg_pkg::XLEN-1:0]     mem_rdata_i,
  output logic [dcache_cfg_pkg::ADDR_W-1:0]   mem_waddr_o,
  output logic [7:0]                          mem_wlen_o,
  output logic [dcache_cfg_pkg::XLEN/8-1:0]   mem_wmask_o,
  output logic [dcache_cfg_pkg::XLEN-1:0]     mem_wdata_o,
  output logic                                mem_wvalid_o,
  input  logic                                mem_wready_i
);

  localparam int OFF_W = dcache_cfg_pkg::OFFSET_W;
  localparam int WSW   = dcache_cfg_pkg::WORD_SEL_W;

  dcache_ctrl_pkg::ctrl_state_e state;
  dcache_ctrl_pkg::access_op_e  op;

  logic [IDX_W-1:0]                    req_idx;
  logic [TAG_W-1:0]                    req_tag;
  logic [WSW-1:0]                      req_word;
  logic                                is_uc;
  logic                                pend;      // second idle cycle, lookup result valid
  logic [WSW-1:0]                      cnt;       // beat counter
  logic                                r_hs;
  logic                                w_hs;
  logic                                last;
  logic [dcache_cfg_pkg::XLEN-1:0]     wdata_q;
  logic [dcache_cfg_pkg::XLEN-1:0]     uc_rdata;
  logic [dcache_cfg_pkg::ADDR_W-1:0]   line_base;
  logic [dcache_cfg_pkg::ADDR_W-1:0]   victim_base;

  assign req_tag     = req_addr_i[dcache_cfg_pkg::ADDR_W-1 -: TAG_W];
  assign req_idx     = req_addr_i[OFF_W +: IDX_W];
  assign req_word    = req_addr_i[OFF_W-1 -: WSW];
  assign is_uc       = req_addr_i[dcache_cfg_pkg::ADDR_W-1 -: 4] == dcache_cfg_pkg::MMIO_BASE;
  assign line_base   = {req_tag, req_idx, {OFF_W{1'b0}}};
  assign victim_base = {victim_tag_i, req_idx, {OFF_W{1'b0}}};
  assign r_hs        = mem_rvalid_o & mem_rready_i;
  assign w_hs        = mem_wvalid_o & mem_wready_i;
  assign last        = cnt == WSW'(dcache_cfg_pkg::BURST_LEN);

  always_comb begin
    if (is_uc) begin
      op = dcache_ctrl_pkg::OP_UNCACHED;
    end else if (hit_i) begin
      op = req_write_i ? dcache_ctrl_pkg::OP_WRITE_HIT : dcache_ctrl_pkg::OP_READ_HIT;
    end else begin
      op = req_write_i ? dcache_ctrl_pkg::OP_WRITE_MISS : dcache_ctrl_pkg::OP_READ_MISS;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= dcache_ctrl_pkg::RESET;
      pend         <= 1'b0;
      cnt          <= '0;
      mem_rvalid_o <= 1'b0;
      mem_wvalid_o <= 1'b0;
    end else begin
      case (state)
        dcache_ctrl_pkg::RESET: state <= dcache_ctrl_pkg::IDLE;
        dcache_ctrl_pkg::IDLE: begin
          pend <= req_valid_i & ~pend;
          if (pend) begin
            case (op)
              dcache_ctrl_pkg::OP_READ_HIT,
              dcache_ctrl_pkg::OP_WRITE_HIT: state <= dcache_ctrl_pkg::RESPOND;
              dcache_ctrl_pkg::OP_READ_MISS: begin
                cnt <= '0;
                if (dirty_i) begin
                  state        <= dcache_ctrl_pkg::WRITE_BACK;
                  mem_wvalid_o <= 1'b1;
                  mem_waddr_o  <= victim_base;
                  mem_wlen_o   <= 8'(dcache_cfg_pkg::BURST_LEN);
                  mem_wmask_o  <= '1;
                end else begin
                  state        <= dcache_ctrl_pkg::REFILL;
                  mem_rvalid_o <= 1'b1;
                  mem_raddr_o  <= line_base;
                  mem_rlen_o   <= 8'(dcache_cfg_pkg::BURST_LEN);
                end
              end
              default: begin  // write miss or uncached, one beat
                if (req_write_i) begin
                  state <= (op == dcache_ctrl_pkg::OP_UNCACHED) ?
                           dcache_ctrl_pkg::UNCACHED_WRITE : dcache_ctrl_pkg::WRITE_MISS;
                  mem_wvalid_o <= 1'b1;
                  mem_waddr_o  <= req_addr_i;
                  mem_wlen_o   <= 8'd0;
                  mem_wmask_o  <= req_mask_i;
                  wdata_q      <= req_wdata_i;
                end else begin
                  state        <= dcache_ctrl_pkg::UNCACHED_READ;
                  mem_rvalid_o <= 1'b1;
                  mem_raddr_o  <= req_addr_i;
                  mem_rlen_o   <= 8'd0;
                end
              end
            endcase
          end
        end
        dcache_ctrl_pkg::WRITE_BACK: begin
          if (w_hs) begin
            cnt <= cnt + 1'b1;  // wraps to zero for the refill
            if (last) begin
              state        <= dcache_ctrl_pkg::REFILL;
              mem_wvalid_o <= 1'b0;
              mem_rvalid_o <= 1'b1;
              mem_raddr_o  <= line_base;
              mem_rlen_o   <= 8'(dcache_cfg_pkg::BURST_LEN);
            end
          end
        end
        dcache_ctrl_pkg::REFILL: begin
          if (r_hs) begin
            cnt <= cnt + 1'b1;
            if (last) begin
              state        <= dcache_ctrl_pkg::IDLE;  // retry lookup, now a hit
              mem_rvalid_o <= 1'b0;
            end
          end
        end
        dcache_ctrl_pkg::WRITE_MISS,
        dcache_ctrl_pkg::UNCACHED_WRITE: begin
          if (w_hs) begin
            state        <= dcache_ctrl_pkg::RESPOND;
            mem_wvalid_o <= 1'b0;
          end
        end
        dcache_ctrl_pkg::UNCACHED_READ: begin
          if (r_hs) begin
            state        <= dcache_ctrl_pkg::RESPOND;
            mem_rvalid_o <= 1'b0;
            uc_rdata     <= mem_rdata_i;
          end
        end
        default: state <= dcache_ctrl_pkg::IDLE;  // RESPOND
      endcase
    end
  end

  always_comb begin
    arr.index    = req_idx;
    arr.word_sel = req_word;
    arr.wdata    = req_wdata_i;
    arr.wmask    = req_mask_i;
    arr.wen      = 1'b0;
    case (state)
      dcache_ctrl_pkg::IDLE: begin
        if (pend && op == dcache_ctrl_pkg::OP_READ_MISS) begin
          arr.word_sel = '0;  // first victim word ready for write-back
        end
        arr.wen = pend && op == dcache_ctrl_pkg::OP_WRITE_HIT && |req_mask_i;
      end
      dcache_ctrl_pkg::WRITE_BACK: arr.word_sel = w_hs ? cnt + 1'b1 : cnt;  // prefetch next
      dcache_ctrl_pkg::REFILL: begin
        arr.word_sel = cnt;
        arr.wdata    = mem_rdata_i;
        arr.wmask    = '1;
        arr.wen      = r_hs;
      end
      default: ;
    endcase
  end

  assign lookup_index_o = req_idx;
  assign lookup_tag_o   = req_tag;
  assign tag_wen_o      = (state == dcache_ctrl_pkg::REFILL) & r_hs & last;
  assign dirty_wen_o    = (state == dcache_ctrl_pkg::IDLE) & pend &
                          (op == dcache_ctrl_pkg::OP_WRITE_HIT);
  assign dirty_val_o    = req_write_i;
  assign mem_wdata_o    = (state == dcache_ctrl_pkg::WRITE_BACK) ? arr.rdata : wdata_q;
  assign resp_ready_o   = state == dcache_ctrl_pkg::RESPOND;
  assign resp_rdata_o   = is_uc ? uc_rdata : arr.rdata;

  a_one_channel: assert property (@(posedge clk) disable iff (rst)
    !(mem_rvalid_o && mem_wvalid_o));

  a_raddr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid_o && !mem_rready_i |=> $stable(mem_raddr_o));

  a_waddr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wvalid_o && !mem_wready_i |=> $stable(mem_waddr_o));

endmodule

//--- dcache_data.sv
`timescale 1ns/1ps

module dcache_data #(
  parameter int NUM_LINES = 64,
  localparam int IDX_W = dcache_cfg_pkg::index_w_of(NUM_LINES),
  localparam int DEPTH = NUM_LINES * dcache_cfg_pkg::WORDS_PER_LINE
) (
  input logic              clk,
  input logic              rst,
  dcache_array_if.array_mp arr
);

  logic [dcache_cfg_pkg::XLEN-1:0]             mem [DEPTH];
  logic [IDX_W+dcache_cfg_pkg::WORD_SEL_W-1:0] addr;

  assign addr = {arr.index, arr.word_sel};  // line-major word address

  always_ff @(posedge clk) begin
    if (arr.wen) begin
      for (int b = 0; b < dcache_cfg_pkg::XLEN / 8; b++) begin
        if (arr.wmask[b]) begin
          mem[addr][8*b +: 8] <= arr.wdata[8*b +: 8];  // byte merge
        end
      end
    end
    arr.rdata <= mem[addr];  // old data on a same-cycle write
  end

  a_mask_set: assert property (@(posedge clk) disable iff (rst)
    arr.wen |-> |arr.wmask);

endmodule

//--- dcache_tag.sv
`timescale 1ns/1ps

module dcache_tag #(
  parameter int NUM_LINES = 64,
  localparam int IDX_W = dcache_cfg_pkg::index_w_of(NUM_LINES),
  localparam int TAG_W = dcache_cfg_pkg::tag_w_of(NUM_LINES)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [IDX_W-1:0] index_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic             tag_wen_i,
  input  logic             dirty_wen_i,
  input  logic             dirty_val_i,
  output logic             hit_o,
  output logic             dirty_o,
  output logic [TAG_W-1:0] victim_tag_o
);

  logic [TAG_W-1:0]     tag_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;
  logic [IDX_W:0]       clr_cnt;  // msb set once every line is swept
  logic                 swept;
  logic [TAG_W-1:0]     rd_tag;
  logic                 rd_valid;
  logic                 rd_dirty;

  // lines the sweep has not reached yet read as invalid and clean
  assign swept = {1'b0, index_i} < clr_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      clr_cnt <= '0;
    end else if (!clr_cnt[IDX_W]) begin
      clr_cnt <= clr_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!clr_cnt[IDX_W]) begin
      valid_q[clr_cnt[IDX_W-1:0]] <= 1'b0;
      dirty_q[clr_cnt[IDX_W-1:0]] <= 1'b0;
    end
    if (tag_wen_i) begin  // refill done, line clean
      tag_mem[index_i] <= tag_i;
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= 1'b0;
    end else if (dirty_wen_i) begin
      dirty_q[index_i] <= dirty_val_i;
    end
    rd_tag   <= tag_mem[index_i];
    rd_valid <= valid_q[index_i] & swept;
    rd_dirty <= dirty_q[index_i] & swept;
  end

  assign hit_o        = rd_valid & (rd_tag == tag_i);
  assign dirty_o      = rd_dirty;
  assign victim_tag_o = rd_tag;  // old occupant, for write-back address

  a_one_write: assert property (@(posedge clk) disable iff (rst)
    !(tag_wen_i && dirty_wen_i));

endmodule

//--- dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if #(
  parameter int NUM_LINES = 64
);

  localparam int IDX_W = dcache_cfg_pkg::index_w_of(NUM_LINES);

  logic [IDX_W-1:0]                     index;
  logic [dcache_cfg_pkg::WORD_SEL_W-1:0] word_sel;
  logic [dcache_cfg_pkg::XLEN-1:0]       wdata;
  logic [dcache_cfg_pkg::XLEN/8-1:0]     wmask;  // one bit per byte
  logic                                  wen;
  logic [dcache_cfg_pkg::XLEN-1:0]       rdata;  // registered word

  modport ctrl_mp (
    output index,
    output word_sel,
    output wdata,
    output wmask,
    output wen,
    input  rdata
  );

  modport array_mp (
    input  index,
    input  word_sel,
    input  wdata,
    input  wmask,
    input  wen,
    output rdata
  );

endinterface

//--- dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

  typedef enum logic [2:0] {
    RESET,
    IDLE,
    WRITE_BACK,      // dirty victim burst out
    REFILL,          // line burst in
    WRITE_MISS,      // single beat, no allocate
    UNCACHED_READ,
    UNCACHED_WRITE,
    RESPOND          // one-cycle answer to the cpu
  } ctrl_state_e;

  typedef enum logic [2:0] {
    OP_READ_HIT,
    OP_WRITE_HIT,
    OP_READ_MISS,
    OP_WRITE_MISS,
    OP_UNCACHED
  } access_op_e;

endpackage

//--- dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  localparam int ADDR_W         = 32;  // cpu and memory address width
  localparam int XLEN           = 64;  // cpu data word
  localparam int OFFSET_W       = 6;   // 64-byte lines
  localparam int WORDS_PER_LINE = 8;
  localparam int WORD_SEL_W     = 3;   // word within a line
  localparam int BURST_LEN      = 7;   // length field, eight beats

  // top nibble of the uncached window
  localparam logic [3:0] MMIO_BASE = 4'hA;

  function automatic int index_w_of(input int lines);
    return $clog2(lines);
  endfunction

  function automatic int tag_w_of(input int lines);
    return ADDR_W - OFFSET_W - index_w_of(lines);
  endfunction

endpackage
